//--- sources.f
+incdir+common
common/mist_pkg.sv
hw/spi_byte_rx.sv
user_io/user_io_cmd.sv
data_io/data_io_load.sv
hw/video_out.sv
hw/mist_base.sv
verif/tb_mist_base.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mist_base testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_mist_base --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mist_base)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Finished with no errors'; then
    exit 0
fi
exit 1

//--- verif/tb_mist_base.sv
//##############################
// tb_mist_base
// Random-stimulus testbench for the platform base
// SPI host driver, reference models and checks
//##############################

`timescale 1ns/100ps
`default_nettype none

`include "mist_defs.svh"

module tb_mist_base;

// About 200 SPI bytes at 80 cycles, 2000 video cycles, margin on top
localparam int MAX_CYCLES = 40000;

logic clk_rgb, rst_n, spi_sck, spi_di, spi_ss2, conf_data0;
mist_pkg::game_video_t  game;
mist_pkg::board_video_t board;
mist_pkg::vga_video_t   vga;
mist_pkg::joy_word_t    joy0, joy1;
mist_pkg::status_word_t status;
mist_pkg::ioctl_t       ioctl;
logic                   downloading;

integer seed = 3914;
int errors, errs_at_start, test_cnt, fails, wr_count, cycles;
logic [7:0]  tx_q[$];                          // Bytes of the next SPI transfer
logic [29:0] wr_exp[$];                        // Expected {addr, data} writes
logic [29:0] wr_next;
logic [7:0]  cfg_cmds[3] = '{`UIO_JOY0, `UIO_JOY1, `UIO_STATUS};
mist_pkg::joy_word_t    exp_joy0, exp_joy1;
mist_pkg::status_word_t exp_status;
mist_pkg::video_cfg_t   exp_vcfg;
mist_pkg::rom_addr_t    exp_addr;
logic                   exp_dl;

mist_pkg::game_video_t  g_stim;
mist_pkg::board_video_t b_stim;
mist_pkg::vga_video_t   exp_v;

mist_base uut (
    .clk_rgb       ( clk_rgb     ),
    .rst_n_i       ( rst_n       ),
    .spi_sck_i     ( spi_sck     ),
    .spi_di_i      ( spi_di      ),
    .spi_ss2_i     ( spi_ss2     ),
    .conf_data0_i  ( conf_data0  ),
    .game_i        ( game        ),
    .board_i       ( board       ),
    .vga_o         ( vga         ),
    .joystick0_o   ( joy0        ),
    .joystick1_o   ( joy1        ),
    .status_o      ( status      ),
    .ioctl_o       ( ioctl       ),
    .downloading_o ( downloading )
);

initial begin
    clk_rgb = 1'b0;
    forever #10 clk_rgb = ~clk_rgb;
end

always @(posedge clk_rgb) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end
end

// Every write pulse must match the head of the expected queue
always @(posedge clk_rgb) begin
    if (ioctl.wr) begin
        wr_count++;
        if (wr_exp.size() == 0) begin
            $display("Unexpected download write at address %h", ioctl.addr);
            errors++;
        end else begin
            wr_next = wr_exp.pop_front();
            if ({ioctl.addr, ioctl.data} !== wr_next) begin
                $display("** Error: ioctl_o addr/data expected %h got %h",
                         wr_next, {ioctl.addr, ioctl.data});
                errors++;
            end
        end
    end
end

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_rgb);
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("** Error: %s expected %h got %h", name, exp, act);
        errors++;
    end
endtask

task automatic check_cfg();
    check_val("joystick0_o", exp_joy0, joy0);
    check_val("joystick1_o", exp_joy1, joy1);
    check_val("status_o", exp_status, status);
endtask

task automatic check_writes_done();
    if (wr_exp.size() != 0) begin
        $display("%0d expected download writes never arrived", wr_exp.size());
        errors++;
        wr_exp.delete();
    end
endtask

task automatic end_test(input string name);
    test_cnt++;
    if (errors == errs_at_start) begin
        $display("Test %0d %s: passed", test_cnt, name);
    end else begin
        fails++;
        $display("Test %0d %s: failed, %0d errors", test_cnt, name, errors - errs_at_start);
    end
    errs_at_start = errors;
endtask

task automatic select_line(input bit to_dl, input logic level);
    if (to_dl)
        spi_ss2 <= level;
    else
        conf_data0 <= level;
endtask

// Mode 0, data set while SCK is low
task automatic shift_bit(input logic b);
    spi_di <= b;
    wait_cycles(4);
    spi_sck <= 1'b1;
    wait_cycles(4);
    spi_sck <= 1'b0;
endtask

task automatic spi_send(input bit to_dl);
    @(posedge clk_rgb);
    select_line(to_dl, 1'b0);
    wait_cycles(4);
    foreach (tx_q[i])
        for (int k = 7; k >= 0; k--)
            shift_bit(tx_q[i][k]);
    wait_cycles(4);
    select_line(to_dl, 1'b1);
    wait_cycles(8);
endtask

task automatic spi_partial(input bit to_dl, input int nbits);
    logic [31:0] rnd;
    @(posedge clk_rgb);
    select_line(to_dl, 1'b0);
    wait_cycles(4);
    for (int k = 0; k < nbits; k++) begin
        rnd = $random(seed);
        shift_bit(rnd[0]);
    end
    wait_cycles(4);
    select_line(to_dl, 1'b1);
    wait_cycles(8);
endtask

task automatic load_word(input logic [7:0] cmd, input logic [31:0] word);
    tx_q.delete();
    tx_q.push_back(cmd);
    for (int k = 0; k < 4; k++)
        tx_q.push_back(word[8*k +: 8]);     // LSB first
endtask

task automatic load_arg(input logic [7:0] cmd, input logic [7:0] arg);
    tx_q.delete();
    tx_q.push_back(cmd);
    tx_q.push_back(arg);
endtask

task automatic load_data(input logic [7:0] cmd, input int n);
    tx_q.delete();
    tx_q.push_back(cmd);
    repeat (n) tx_q.push_back(8'($random(seed)));
endtask

// Register model of the configuration commands
task automatic cfg_xfer();
    for (int i = 1; i < tx_q.size() && i <= 4; i++) begin
        case (tx_q[0])
            `UIO_JOY0:   exp_joy0[8*(i-1) +: 8] = tx_q[i];
            `UIO_JOY1:   exp_joy1[8*(i-1) +: 8] = tx_q[i];
            `UIO_STATUS: exp_status[8*(i-1) +: 8] = tx_q[i];
            `UIO_VMODE: begin
                if (i == 1) begin
                    exp_vcfg.scandoubler_disable = tx_q[i][4];
                    exp_vcfg.ypbpr               = tx_q[i][5];
                end
            end
            default: ;
        endcase
    end
    spi_send(1'b0);
endtask

// Download model, fills the expected write queue
task automatic dl_xfer();
    for (int i = 1; i < tx_q.size(); i++) begin
        if (tx_q[0] == `DIO_FILE_TX && i == 1) begin
            exp_dl = |tx_q[i];
            if (exp_dl)
                exp_addr = '0;
        end else if (tx_q[0] == `DIO_FILE_DAT && exp_dl) begin
            wr_exp.push_back({exp_addr, tx_q[i]});
            exp_addr++;
        end
    end
    spi_send(1'b1);
endtask

function automatic mist_pkg::rgb6_t clamp63(input integer v);
    if (v < 0)
        return 6'd0;
    if (v > 63)
        return 6'd63;
    return v[5:0];
endfunction

function automatic mist_pkg::vga_video_t video_model(input mist_pkg::video_cfg_t c,
                                                     input mist_pkg::game_video_t g,
                                                     input mist_pkg::board_video_t b);
    mist_pkg::vga_video_t v;
    integer r, gr, bl, y, pb, pr;
    logic hs_w, vs_w;
    if (c.scandoubler_disable) begin
        r    = {g.r, g.r[3:2]};
        gr   = {g.g, g.g[3:2]};
        bl   = {g.b, g.b[3:2]};
        hs_w = ~g.hs;
        vs_w = ~g.vs;
    end else begin
        r    = b.r;
        gr   = b.g;
        bl   = b.b;
        hs_w = b.hs;
        vs_w = b.vs;
    end
    y  = (19*r + 38*gr + 7*bl) >>> 6;
    pb = 32 + ((32*bl - 11*r - 21*gr) >>> 6);
    pr = 32 + ((32*r - 27*gr - 5*bl) >>> 6);
    if (c.ypbpr) begin
        v.r = clamp63(pr);
        v.g = clamp63(y);
        v.b = clamp63(pb);
    end else begin
        v.r = r[5:0];
        v.g = gr[5:0];
        v.b = bl[5:0];
    end
    if (c.scandoubler_disable || c.ypbpr) begin
        v.hs = ~(hs_w ^ vs_w);              // Composite sync
        v.vs = 1'b1;
    end else begin
        v.hs = hs_w;
        v.vs = vs_w;
    end
    return v;
endfunction

task automatic run_video(input logic sd, input logic yp);
    logic [31:0] rnd;
    rnd = $random(seed);
    load_arg(`UIO_VMODE, (rnd[7:0] & 8'hCF) | {2'b00, yp, sd, 4'h0});
    cfg_xfer();
    for (int i = 0; i <= 500; i++) begin
        rnd    = $random(seed);
        g_stim = rnd[13:0];
        rnd    = $random(seed);
        b_stim = rnd[19:0];
        @(posedge clk_rgb);
        game  <= g_stim;
        board <= b_stim;
        @(negedge clk_rgb);             // vga now holds the previous pixel
        if (i > 0)
            check_val("vga_o", 32'(exp_v), 32'(vga));
        exp_v = video_model(exp_vcfg, g_stim, b_stim);
    end
endtask

initial begin
    logic [31:0] rnd;
    int wr_base;
    rst_n = 1'b0;
    spi_sck = 1'b0;
    spi_di = 1'b0;
    spi_ss2 = 1'b1;
    conf_data0 = 1'b1;
    game = '0;
    board = '0;
    exp_joy0 = '0;
    exp_joy1 = '0;
    exp_status = '0;
    exp_vcfg = '0;
    exp_addr = '0;
    exp_dl = 1'b0;
    wait_cycles(5);
    rst_n <= 1'b1;
    wait_cycles(2);

    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 3; c++) begin
            rnd = $random(seed);
            load_word(cfg_cmds[c], rnd);
            cfg_xfer();
            check_cfg();
        end
    end
    rnd = $random(seed);
    load_word(8'h37, rnd);                  // Not a known command
    cfg_xfer();
    check_cfg();
    end_test("configuration registers");

    rnd = $random(seed);
    load_arg(`DIO_FILE_TX, rnd[7:0] | 8'h01);
    dl_xfer();
    check_val("downloading_o", 32'(exp_dl), 32'(downloading));
    wr_base = wr_count;
    load_data(`DIO_FILE_DAT, 64);
    dl_xfer();
    check_val("ioctl_o.wr pulse count", 32'd64, 32'(wr_count - wr_base));
    check_writes_done();
    load_arg(`DIO_FILE_TX, 8'h00);
    dl_xfer();
    check_val("downloading_o", 32'(exp_dl), 32'(downloading));
    end_test("ROM download");

    wr_base = wr_count;
    load_data(`DIO_FILE_DAT, 16);
    dl_xfer();
    check_val("ioctl_o.wr pulse count", 32'd0, 32'(wr_count - wr_base));
    load_arg(`DIO_FILE_TX, 8'h80);
    dl_xfer();
    wr_base = wr_count;
    load_data(`DIO_FILE_DAT, 8);
    dl_xfer();
    check_val("ioctl_o.wr pulse count", 32'd8, 32'(wr_count - wr_base));
    check_writes_done();
    load_arg(`DIO_FILE_TX, 8'h00);
    dl_xfer();
    end_test("writes ignored when idle");

    spi_partial(1'b0, 5);
    rnd = $random(seed);
    load_word(`UIO_JOY1, rnd);
    cfg_xfer();
    check_cfg();
    end_test("aborted byte");

    run_video(1'b0, 1'b0);
    run_video(1'b1, 1'b0);
    run_video(1'b0, 1'b1);
    run_video(1'b1, 1'b1);
    end_test("video modes");

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fails, errors);
    if (errors == 0)
        $display("Finished with no errors");
    else
        $display("Finished with errors");
    $finish;
end

endmodule

`default_nettype wire

//--- hw/mist_base.sv
//##############################
// mist_base
// Platform base, host SPI links and video output
//##############################

`timescale 1ns/100ps
`default_nettype none

module mist_base (
    input  wire                         clk_rgb,
    input  wire                         rst_n_i,
    input  wire                         spi_sck_i,
    input  wire                         spi_di_i,
    input  wire                         spi_ss2_i,
    input  wire                         conf_data0_i,
    input  wire mist_pkg::game_video_t  game_i,
    input  wire mist_pkg::board_video_t board_i,
    output mist_pkg::vga_video_t        vga_o,
    output mist_pkg::joy_word_t         joystick0_o,
    output mist_pkg::joy_word_t         joystick1_o,
    output mist_pkg::status_word_t      status_o,
    output mist_pkg::ioctl_t            ioctl_o,
    output logic                        downloading_o
);

mist_pkg::spi_byte_t  cfg_byte;
mist_pkg::spi_byte_t  dl_byte;
mist_pkg::video_cfg_t video_cfg;

// Configuration link on CONF_DATA0
spi_byte_rx u_cfg_rx (
    .clk_rgb    ( clk_rgb      ),
    .rst_n_i    ( rst_n_i      ),
    .sck_i      ( spi_sck_i    ),
    .sdi_i      ( spi_di_i     ),
    .ss_n_i     ( conf_data0_i ),
    .byte_o     ( cfg_byte     )
);

spi_byte_rx u_dl_rx (           // ROM download on SS2
    .clk_rgb    ( clk_rgb      ),
    .rst_n_i    ( rst_n_i      ),
    .sck_i      ( spi_sck_i    ),
    .sdi_i      ( spi_di_i     ),
    .ss_n_i     ( spi_ss2_i    ),
    .byte_o     ( dl_byte      )
);

user_io_cmd u_user_io (
    .clk_rgb     ( clk_rgb     ),
    .rst_n_i     ( rst_n_i     ),
    .byte_i      ( cfg_byte    ),
    .joystick0_o ( joystick0_o ),
    .joystick1_o ( joystick1_o ),
    .status_o    ( status_o    ),
    .video_cfg_o ( video_cfg   )
);

data_io_load u_data_io (
    .clk_rgb       ( clk_rgb       ),
    .rst_n_i       ( rst_n_i       ),
    .byte_i        ( dl_byte       ),
    .ioctl_o       ( ioctl_o       ),
    .downloading_o ( downloading_o )
);

video_out u_video (
    .clk_rgb    ( clk_rgb   ),
    .rst_n_i    ( rst_n_i   ),
    .cfg_i      ( video_cfg ),
    .game_i     ( game_i    ),
    .board_i    ( board_i   ),
    .vga_o      ( vga_o     )
);

endmodule

`default_nettype wire

//--- hw/video_out.sv
//##############################
// video_out
// Source select, YPbPr and sync forming
//##############################

`timescale 1ns/100ps
`default_nettype none

`include "mist_defs.svh"

module video_out (
    input  wire                        clk_rgb,
    input  wire                        rst_n_i,
    input  wire mist_pkg::video_cfg_t   cfg_i,
    input  wire mist_pkg::game_video_t  game_i,
    input  wire mist_pkg::board_video_t board_i,
    output mist_pkg::vga_video_t        vga_o
);

mist_pkg::rgb6_t    src_r, src_g, src_b;
logic               hs_w, vs_w, csync;
logic signed [13:0] r_s, g_s, b_s;
logic signed [13:0] y_sum, pb_sum, pr_sum;
logic signed [13:0] y_val, pb_val, pr_val;

function automatic mist_pkg::rgb6_t clamp6(input logic signed [13:0] v);
    if (v < 14'sd0)
        return 6'd0;
    else if (v > 14'sd63)
        return 6'd63;
    else
        return v[5:0];
endfunction

always_comb begin
    if (cfg_i.scandoubler_disable) begin
        src_r = {game_i.r, game_i.r[3:2]};  // 4 to 6 bits
        src_g = {game_i.g, game_i.g[3:2]};
        src_b = {game_i.b, game_i.b[3:2]};
        hs_w  = ~game_i.hs;
        vs_w  = ~game_i.vs;
    end else begin
        src_r = board_i.r;
        src_g = board_i.g;
        src_b = board_i.b;
        hs_w  = board_i.hs;
        vs_w  = board_i.vs;
    end
    csync = ~(hs_w ^ vs_w);
end

assign r_s = $signed({8'd0, src_r});
assign g_s = $signed({8'd0, src_g});
assign b_s = $signed({8'd0, src_b});

assign y_sum  = `YPBPR_Y_R * r_s + `YPBPR_Y_G * g_s + `YPBPR_Y_B * b_s;
assign pb_sum = `YPBPR_PB_B * b_s - `YPBPR_PB_R * r_s - `YPBPR_PB_G * g_s;
assign pr_sum = `YPBPR_PR_R * r_s - `YPBPR_PR_G * g_s - `YPBPR_PR_B * b_s;

assign y_val  = y_sum >>> `YPBPR_SHIFT;
assign pb_val = (pb_sum >>> `YPBPR_SHIFT) + `YPBPR_OFS;    // Centre at mid scale
assign pr_val = (pr_sum >>> `YPBPR_SHIFT) + `YPBPR_OFS;

always_ff @(posedge clk_rgb or negedge rst_n_i) begin
    if (!rst_n_i) begin
        vga_o <= '0;
    end else begin
        if (cfg_i.ypbpr) begin
            vga_o.r <= clamp6(pr_val);
            vga_o.g <= clamp6(y_val);
            vga_o.b <= clamp6(pb_val);
        end else begin
            vga_o.r <= src_r;
            vga_o.g <= src_g;
            vga_o.b <= src_b;
        end
        // SCART and component cables take csync on HS and a high VS
        if (cfg_i.scandoubler_disable || cfg_i.ypbpr) begin
            vga_o.hs <= csync;
            vga_o.vs <= 1'b1;
        end else begin
            vga_o.hs <= hs_w;
            vga_o.vs <= vs_w;
        end
    end
end

a_vs_high: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
    (cfg_i.scandoubler_disable || cfg_i.ypbpr) |=> vga_o.vs);

endmodule

`default_nettype wire

//--- data_io/data_io_load.sv
//##############################
// data_io_load
// ROM download commands into byte writes
//##############################

`timescale 1ns/100ps
`default_nettype none

`include "mist_defs.svh"

module data_io_load (
    input  wire                      clk_rgb,
    input  wire                      rst_n_i,
    input  wire mist_pkg::spi_byte_t byte_i,
    output mist_pkg::ioctl_t         ioctl_o,
    output logic                     downloading_o
);

logic [7:0]          cmd_q;
logic                tx_arg_done;   // FILE_TX takes a single argument
mist_pkg::rom_addr_t addr_cnt;
logic                dat_byte;
logic                wr_q;
mist_pkg::rom_addr_t addr_q;
logic [7:0]          data_q;

assign dat_byte = byte_i.stb & ~byte_i.first & (cmd_q == `DIO_FILE_DAT) & downloading_o;

always_ff @(posedge clk_rgb or negedge rst_n_i) begin
    if (!rst_n_i) begin
        cmd_q         <= '0;
        tx_arg_done   <= 1'b0;
        downloading_o <= 1'b0;
        addr_cnt      <= '0;
        wr_q          <= 1'b0;
    end else begin
        wr_q <= 1'b0;
        if (byte_i.stb && byte_i.first) begin
            cmd_q       <= byte_i.data;
            tx_arg_done <= 1'b0;
        end else if (byte_i.stb && cmd_q == `DIO_FILE_TX && !tx_arg_done) begin
            tx_arg_done   <= 1'b1;
            downloading_o <= |byte_i.data;
            if (|byte_i.data)
                addr_cnt <= '0;     // New file starts at zero
        end else if (dat_byte) begin
            wr_q     <= 1'b1;
            addr_cnt <= addr_cnt + 1'b1;    // Wraps at 2^22
        end
    end
end

always_ff @(posedge clk_rgb) begin
    if (dat_byte) begin
        addr_q <= addr_cnt;
        data_q <= byte_i.data;
    end
end

assign ioctl_o = '{addr: addr_q, data: data_q, wr: wr_q};

a_wr_in_dl: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
    ioctl_o.wr |-> downloading_o);

endmodule

`default_nettype wire

//--- user_io/user_io_cmd.sv
//##############################
// user_io_cmd
// Host configuration commands into core registers
//##############################

`timescale 1ns/100ps
`default_nettype none

`include "mist_defs.svh"

module user_io_cmd (
    input  wire                     clk_rgb,
    input  wire                     rst_n_i,
    input  wire mist_pkg::spi_byte_t byte_i,
    output mist_pkg::joy_word_t     joystick0_o,
    output mist_pkg::joy_word_t     joystick1_o,
    output mist_pkg::status_word_t  status_o,
    output mist_pkg::video_cfg_t    video_cfg_o
);

logic [7:0] cmd_q;
logic [2:0] byte_idx;   // Data bytes seen, saturates at 4

always_ff @(posedge clk_rgb or negedge rst_n_i) begin
    if (!rst_n_i) begin
        cmd_q       <= '0;
        byte_idx    <= '0;
        joystick0_o <= '0;
        joystick1_o <= '0;
        status_o    <= '0;
        video_cfg_o <= '0;
    end else if (byte_i.stb) begin
        if (byte_i.first) begin
            cmd_q    <= byte_i.data;
            byte_idx <= '0;
        end else if (byte_idx < 3'd4) begin
            byte_idx <= byte_idx + 3'd1;
            // LSB lane arrives first
            case (cmd_q)
                `UIO_JOY0:   joystick0_o[8*byte_idx[1:0] +: 8] <= byte_i.data;
                `UIO_JOY1:   joystick1_o[8*byte_idx[1:0] +: 8] <= byte_i.data;
                `UIO_STATUS: status_o[8*byte_idx[1:0] +: 8]    <= byte_i.data;
                `UIO_VMODE: begin
                    if (byte_idx == 3'd0) begin
                        video_cfg_o.scandoubler_disable <= byte_i.data[4];
                        video_cfg_o.ypbpr               <= byte_i.data[5];
                    end
                end
                default: ;  // Unknown command
            endcase
        end
    end
end

a_idx_range: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
    byte_idx <= 3'd4);

endmodule

`default_nettype wire

//--- hw/spi_byte_rx.sv
//##############################
// spi_byte_rx
// SPI mode 0 byte receiver, MSB first
//##############################

`timescale 1ns/100ps
`default_nettype none

module spi_byte_rx (
    input  wire                 clk_rgb,
    input  wire                 rst_n_i,
    input  wire                 sck_i,
    input  wire                 sdi_i,
    input  wire                 ss_n_i,
    output mist_pkg::spi_byte_t byte_o
);

logic [2:0] sck_q;      // Two sync stages plus edge history
logic [1:0] sdi_q;
logic [1:0] ss_q;
logic       sck_rise;
logic [2:0] bit_cnt;
logic       first_pend;
logic       first_q;
logic       stb_q;
logic [7:0] shift_q;

assign sck_rise = sck_q[1] & ~sck_q[2];

always_ff @(posedge clk_rgb or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sck_q      <= '0;
        sdi_q      <= '0;
        ss_q       <= '1;   // Deselected
        bit_cnt    <= '0;
        first_pend <= 1'b1;
        first_q    <= 1'b0;
        stb_q      <= 1'b0;
    end else begin
        sck_q <= {sck_q[1:0], sck_i};
        sdi_q <= {sdi_q[0], sdi_i};
        ss_q  <= {ss_q[0], ss_n_i};
        stb_q <= 1'b0;
        if (ss_q[1]) begin
            // Drops any partial byte
            bit_cnt    <= '0;
            first_pend <= 1'b1;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                stb_q      <= 1'b1;
                first_q    <= first_pend;
                first_pend <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clk_rgb) begin
    if (sck_rise && !ss_q[1])
        shift_q <= {shift_q[6:0], sdi_q[1]};
end

assign byte_o = '{data: shift_q, first: first_q, stb: stb_q};

// At least eight SCK edges lie between two bytes
a_stb_single: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
    byte_o.stb |=> !byte_o.stb);

endmodule

`default_nettype wire

//--- common/mist_pkg.sv
//##############################
// mist_pkg
// Shared types for the MiST platform base
//##############################

`default_nettype none

`include "mist_defs.svh"

package mist_pkg;

    typedef logic [31:0]          joy_word_t;    // Buttons and directions
    typedef logic [31:0]          status_word_t; // Host menu status
    typedef logic [3:0]           rgb4_t;
    typedef logic [5:0]           rgb6_t;
    typedef logic [`MIST_AW-1:0]  rom_addr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       first; // First byte after select low
        logic       stb;
    } spi_byte_t;

    typedef struct packed {
        logic scandoubler_disable;
        logic ypbpr;
    } video_cfg_t;

    typedef struct packed {
        rgb4_t r;
        rgb4_t g;
        rgb4_t b;
        logic  hs;
        logic  vs;
    } game_video_t;

    typedef struct packed {
        rgb6_t r;
        rgb6_t g;
        rgb6_t b;
        logic  hs;
        logic  vs;
    } board_video_t;

    typedef struct packed {
        rgb6_t r;
        rgb6_t g;
        rgb6_t b;
        logic  hs;
        logic  vs;
    } vga_video_t;

    // Download write towards the ROM loader
    typedef struct packed {
        rom_addr_t  addr;
        logic [7:0] data;
        logic       wr;
    } ioctl_t;

endpackage

`default_nettype wire

//--- common/mist_defs.svh
//##############################
// mist_defs
// SPI command codes, widths and colour coefficients
//##############################

`ifndef MIST_DEFS_SVH
`define MIST_DEFS_SVH

`define MIST_AW         22

// Configuration channel commands
`define UIO_JOY0        8'h01
`define UIO_JOY1        8'h02
`define UIO_VMODE       8'h0E
`define UIO_STATUS      8'h1E

// Download channel commands
`define DIO_FILE_TX     8'h53
`define DIO_FILE_DAT    8'h54

// RGB to YPbPr, scaled by 64
`define YPBPR_Y_R       14'sd19
`define YPBPR_Y_G       14'sd38
`define YPBPR_Y_B       14'sd7
`define YPBPR_PB_R      14'sd11
`define YPBPR_PB_G      14'sd21
`define YPBPR_PB_B      14'sd32
`define YPBPR_PR_R      14'sd32
`define YPBPR_PR_G      14'sd27
`define YPBPR_PR_B      14'sd5
`define YPBPR_SHIFT     6
`define YPBPR_OFS       14'sd32

`endif
